/* dv/tb_dma_core_wrap.sv */
`timescale 1ns/1ns
`include "dma_cfg.svh"

module tb_dma_core_wrap import dma_pkg::*; ();

  localparam int unsigned TotalWords    = 8 + 12 + 6 * 16 + 4 * 8 * 4;
  localparam int unsigned TimeoutCycles = TotalWords * 20 + 2000;
  localparam logic [31:0] Seed          = 32'd35429;

  logic                       clk = 1'b0;
  logic                       rst_n;
  logic                       reg_valid, reg_write, reg_ready;
  logic [`DMA_REG_ADDR_W-1:0] reg_addr;
  dma_data_t                  reg_wdata, reg_rdata;
  logic                       mem_req, mem_we, mem_gnt, mem_rvalid;
  dma_addr_t                  mem_addr;
  dma_data_t                  mem_wdata, mem_rdata;

  string       test_name = "reset";
  dma_addr_t   jobs_launched = '0;
  int unsigned stall_cycles = 0;
  int unsigned cycle_cnt = 0;
  logic        guard_on = 1'b0;
  dma_addr_t   guard_lo = '0;
  dma_addr_t   guard_hi = '0;
  logic [31:0] rng_q = Seed;

  always #4 clk = ~clk;

  dma_core_wrap i_dma_core_wrap (
    .clk_i        ( clk        ),
    .rst_n_i      ( rst_n      ),
    .reg_valid_i  ( reg_valid  ),
    .reg_write_i  ( reg_write  ),
    .reg_addr_i   ( reg_addr   ),
    .reg_wdata_i  ( reg_wdata  ),
    .reg_ready_o  ( reg_ready  ),
    .reg_rdata_o  ( reg_rdata  ),
    .mem_req_o    ( mem_req    ),
    .mem_we_o     ( mem_we     ),
    .mem_addr_o   ( mem_addr   ),
    .mem_wdata_o  ( mem_wdata  ),
    .mem_gnt_i    ( mem_gnt    ),
    .mem_rvalid_i ( mem_rvalid ),
    .mem_rdata_i  ( mem_rdata  )
  );

  tb_dma_mem_model #(
    .SEED ( Seed )
  ) i_mem_model (
    .clk_i    ( clk        ),
    .rst_n_i  ( rst_n      ),
    .req_i    ( mem_req    ),
    .we_i     ( mem_we     ),
    .addr_i   ( mem_addr   ),
    .wdata_i  ( mem_wdata  ),
    .gnt_o    ( mem_gnt    ),
    .rvalid_o ( mem_rvalid ),
    .rdata_o  ( mem_rdata  )
  );

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input dma_data_t expected, input dma_data_t actual);
    stop_on_error($sformatf("[ERROR] %s: expected 0x%08h, actual 0x%08h",
                            test_name, expected, actual));
  endtask

  function automatic logic [31:0] lcg_advance(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Source words are preloaded from their address through the LCG
  function automatic dma_data_t preload_word(input dma_addr_t addr);
    return lcg_advance(32'(addr) ^ Seed);
  endfunction

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TimeoutCycles) begin
      stop_on_error($sformatf("run timed out after %0d cycles", cycle_cnt));
    end
  end

  a_idle_after_reset: assert property (@(posedge clk) !rst_n |=> !mem_req)
    else stop_on_error("memory request active right after reset");

  a_mem_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req && !mem_gnt |=>
      mem_req && $stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata))
    else stop_on_error("memory request changed while waiting for a grant");

  a_no_guarded_write: assert property (@(posedge clk) disable iff (!rst_n)
    guard_on && mem_req && mem_we && mem_gnt |-> (mem_addr < guard_lo || mem_addr > guard_hi))
    else stop_on_error("memory write landed in a protected destination area");

  a_ready_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
    reg_ready |-> reg_valid)
    else stop_on_error("register bus ready without a valid request");

  // Holds the request until ready and samples on the falling edge
  task automatic bus_access(input logic wr, input logic [`DMA_REG_ADDR_W-1:0] addr,
                            input dma_data_t wdata, output dma_data_t rdata);
    int unsigned waited;
    waited = 0;
    @(posedge clk);
    reg_valid <= 1'b1;
    reg_write <= wr;
    reg_addr  <= addr;
    reg_wdata <= wdata;
    do begin
      @(negedge clk);
      waited++;
    end while (!reg_ready);
    rdata = reg_rdata;
    if (waited > 1) stall_cycles += waited - 1;
    @(posedge clk);
    reg_valid <= 1'b0;
  endtask

  task automatic write_register(input logic [`DMA_REG_ADDR_W-1:0] addr, input dma_data_t data);
    dma_data_t unused;
    bus_access(1'b1, addr, data, unused);
  endtask

  task automatic read_register(input logic [`DMA_REG_ADDR_W-1:0] addr, output dma_data_t data);
    bus_access(1'b0, addr, '0, data);
  endtask

  task automatic program_job(input dma_nd_job_t job);
    write_register(REG_SRC, dma_data_t'(job.src));
    write_register(REG_DST, dma_data_t'(job.dst));
    write_register(REG_LEN, dma_data_t'(job.len));
    write_register(REG_SRC_STRIDE, dma_data_t'(job.src_stride));
    write_register(REG_DST_STRIDE, dma_data_t'(job.dst_stride));
    write_register(REG_REPS, dma_data_t'(job.reps));
  endtask

  // Ids count accepted launches from zero
  task automatic launch_job();
    dma_data_t id;
    read_register(REG_LAUNCH, id);
    assert (id == dma_data_t'(jobs_launched))
      else report_mismatch(dma_data_t'(jobs_launched), id);
    jobs_launched++;
  endtask

  task automatic wait_all_done();
    dma_data_t rd;
    do begin
      read_register(REG_DONE, rd);
    end while (rd[15:0] != jobs_launched);
    assert (rd == dma_data_t'(jobs_launched))
      else report_mismatch(dma_data_t'(jobs_launched), rd);
  endtask

  task automatic check_copy(input dma_nd_job_t job);
    dma_addr_t s, d;
    for (dma_addr_t r = '0; r < job.reps; r++) begin
      for (dma_addr_t i = '0; i < job.len; i++) begin
        s = job.src + job.src_stride * r + i;
        d = job.dst + job.dst_stride * r + i;
        assert (i_mem_model.mem[d] == preload_word(s))
          else report_mismatch(preload_word(s), i_mem_model.mem[d]);
      end
    end
  endtask

  initial begin
    dma_nd_job_t job;
    dma_nd_job_t rnd_jobs [4];
    dma_data_t   rd;
    dma_data_t   gap_q [12];
    dma_addr_t   gap_addr;
    int unsigned wr_before;

    rst_n     <= 1'b0;
    reg_valid <= 1'b0;
    reg_write <= 1'b0;
    reg_addr  <= '0;
    reg_wdata <= '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    test_name = "reset state";
    assert (mem_req == 1'b0) else report_mismatch(32'd0, 32'(mem_req));
    read_register(REG_DONE, rd);
    assert (rd == 32'd0) else report_mismatch(32'd0, rd);

    test_name = "1D copy";
    job = '{src: 16'h0100, dst: 16'h0200, len: 16'd8,
            src_stride: 16'd0, dst_stride: 16'd0, reps: 16'd1};
    program_job(job);
    launch_job();
    wait_all_done();
    check_copy(job);

    test_name = "2D copy";
    job = '{src: 16'h1000, dst: 16'h2000, len: 16'd4,
            src_stride: 16'd16, dst_stride: 16'd8, reps: 16'd3};
    for (int k = 0; k < 12; k++) begin
      gap_addr = job.dst + dma_addr_t'(8 * (k / 4) + 4 + k % 4);
      gap_q[k] = i_mem_model.mem[gap_addr];
    end
    program_job(job);
    launch_job();
    wait_all_done();
    check_copy(job);
    for (int k = 0; k < 12; k++) begin
      gap_addr = job.dst + dma_addr_t'(8 * (k / 4) + 4 + k % 4);
      assert (i_mem_model.mem[gap_addr] == gap_q[k])
        else report_mismatch(gap_q[k], i_mem_model.mem[gap_addr]);
    end

    // Long jobs so that the FIFO fills up
    test_name = "queued jobs";
    job = '{src: 16'h1100, dst: 16'h2100, len: 16'd16,
            src_stride: 16'd16, dst_stride: 16'd16, reps: 16'd1};
    program_job(job);
    stall_cycles = 0;
    for (int j = 0; j < 6; j++) begin
      write_register(REG_DST, dma_data_t'(16'h2100 + dma_addr_t'(j * 32)));
      launch_job();
    end
    wait_all_done();
    for (int j = 0; j < 6; j++) begin
      job.dst = 16'h2100 + dma_addr_t'(j * 32);
      check_copy(job);
    end
    assert (stall_cycles > 0) else stop_on_error("launch never waited on a full job FIFO");

    test_name = "empty jobs";
    wr_before = i_mem_model.wr_count;
    guard_lo  = 16'h3000;
    guard_hi  = 16'h30ff;
    guard_on  = 1'b1;
    job = '{src: 16'h1200, dst: 16'h3000, len: 16'd0,
            src_stride: 16'd4, dst_stride: 16'd4, reps: 16'd2};
    program_job(job);
    launch_job();
    job.dst  = 16'h3080;
    job.len  = 16'd4;
    job.reps = 16'd0;
    program_job(job);
    launch_job();
    wait_all_done();
    guard_on = 1'b0;
    assert (i_mem_model.wr_count == wr_before)
      else report_mismatch(32'(wr_before), 32'(i_mem_model.wr_count));

    test_name = "random jobs";
    for (int j = 0; j < 4; j++) begin
      rng_q = lcg_advance(rng_q);
      rnd_jobs[j].len        = dma_addr_t'(rng_q[18:16]) + 16'd1;
      rnd_jobs[j].reps       = dma_addr_t'(rng_q[21:20]) + 16'd1;
      rnd_jobs[j].src_stride = rnd_jobs[j].len + dma_addr_t'(rng_q[25:24]);
      rnd_jobs[j].dst_stride = rnd_jobs[j].len + dma_addr_t'(rng_q[27:26]);
      rnd_jobs[j].src        = 16'h4000 + dma_addr_t'(j * 256);
      rnd_jobs[j].dst        = 16'h6000 + dma_addr_t'(j * 256);
      program_job(rnd_jobs[j]);
      launch_job();
    end
    wait_all_done();
    for (int j = 0; j < 4; j++) begin
      check_copy(rnd_jobs[j]);
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

/* dv/tb_dma_mem_model.sv */
`timescale 1ns/1ns
`include "dma_cfg.svh"

module tb_dma_mem_model import dma_pkg::*; #(
  parameter logic [31:0] SEED = 32'd35429
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      req_i,
  input  logic      we_i,
  input  dma_addr_t addr_i,
  input  dma_data_t wdata_i,
  output logic      gnt_o,
  output logic      rvalid_o,
  output dma_data_t rdata_o
);

  dma_data_t   mem [2**`DMA_ADDR_W];
  logic [31:0] rand_q;
  logic [1:0]  gnt_wait_q, rd_wait_q;
  logic        rd_pend_q;
  dma_addr_t   rd_addr_q;
  int unsigned wr_count;

  function automatic logic [31:0] next_rand(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Each word is seeded from its full address
  initial begin
    for (int a = 0; a < 2**`DMA_ADDR_W; a++) begin
      mem[a] = next_rand(32'(a) ^ SEED);
    end
  end

  assign gnt_o    = req_i && !rd_pend_q && (gnt_wait_q == 2'd0);
  assign rvalid_o = rd_pend_q && (rd_wait_q == 2'd0);
  assign rdata_o  = mem[rd_addr_q];

  always @(posedge clk_i) begin
    if (gnt_o && we_i) begin
      mem[addr_i] = wdata_i;
    end
  end

  // Grant and read data delays of 0 to 3 cycles
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rand_q     <= SEED;
      gnt_wait_q <= 2'd0;
      rd_wait_q  <= 2'd0;
      rd_pend_q  <= 1'b0;
      rd_addr_q  <= '0;
      wr_count   <= 0;
    end else begin
      if (req_i && !rd_pend_q && gnt_wait_q != 2'd0) begin
        gnt_wait_q <= gnt_wait_q - 2'd1;
      end
      if (gnt_o) begin
        rand_q     <= next_rand(rand_q);
        gnt_wait_q <= rand_q[17:16];
        if (we_i) begin
          wr_count <= wr_count + 1;
        end else begin
          rd_pend_q <= 1'b1;
          rd_addr_q <= addr_i;
          rd_wait_q <= rand_q[21:20];
        end
      end
      if (rvalid_o) begin
        rd_pend_q <= 1'b0;
      end else if (rd_pend_q && rd_wait_q != 2'd0) begin
        rd_wait_q <= rd_wait_q - 2'd1;
      end
    end
  end

endmodule

/* filelist.f */
+incdir+src
src/dma_pkg.sv
src/dma_burst_if.sv
src/dma_reg_frontend.sv
src/dma_job_fifo.sv
src/dma_nd_midend.sv
src/dma_backend.sv
src/dma_core_wrap.sv
dv/tb_dma_mem_model.sv
dv/tb_dma_core_wrap.sv

/* run.sh */
#!/bin/sh
# Build with Verilator and run, pass only when the pass line shows up
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --timescale 1ns/1ns \
       --top-module tb_dma_core_wrap -f filelist.f -o sim_dma \
  && ./obj_dir/sim_dma | tee /dev/stderr | grep -q "TEST PASSED" \
  && echo "Simulation run ok" \
  || { echo "Simulation run failed"; exit 1; }

/* src/dma_backend.sv */
`timescale 1ns/1ns
`include "dma_cfg.svh"

module dma_backend import dma_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  dma_burst_if.be   burst,
  output logic      burst_done_o,
  output logic      mem_req_o,
  output logic      mem_we_o,
  output dma_addr_t mem_addr_o,
  output dma_data_t mem_wdata_o,
  input  logic      mem_gnt_i,
  input  logic      mem_rvalid_i,
  input  dma_data_t mem_rdata_i,
  output logic      busy_o
);

  typedef enum logic [1:0] {
    BE_IDLE,
    BE_RD_REQ,
    BE_RD_WAIT,
    BE_WR_REQ
  } be_state_e;

  be_state_e state_q;
  dma_addr_t src_q, dst_q, len_q;
  dma_addr_t word_q, word_nxt;
  dma_data_t data_q;
  logic      done_q;
  logic      accept;

  assign burst.ready = (state_q == BE_IDLE);
  assign accept      = burst.valid && burst.ready;
  assign word_nxt    = word_q + 1'b1;

  assign mem_req_o   = (state_q == BE_RD_REQ) || (state_q == BE_WR_REQ);
  assign mem_we_o    = (state_q == BE_WR_REQ);
  assign mem_addr_o  = mem_we_o ? dst_q : src_q;
  assign mem_wdata_o = data_q;

  assign burst_done_o = done_q;
  assign busy_o       = (state_q != BE_IDLE);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= BE_IDLE;
      word_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        BE_IDLE: begin
          if (accept) begin
            word_q <= '0;
            // Empty burst, no memory access
            if (burst.len == '0) begin
              done_q <= 1'b1;
            end else begin
              state_q <= BE_RD_REQ;
            end
          end
        end
        BE_RD_REQ: begin
          if (mem_gnt_i) state_q <= BE_RD_WAIT;
        end
        BE_RD_WAIT: begin
          if (mem_rvalid_i) state_q <= BE_WR_REQ;
        end
        BE_WR_REQ: begin
          if (mem_gnt_i) begin
            word_q <= word_nxt;
            if (word_nxt == len_q) begin
              state_q <= BE_IDLE;
              done_q  <= 1'b1;
            end else begin
              state_q <= BE_RD_REQ;
            end
          end
        end
        default: state_q <= BE_IDLE;
      endcase
    end
  end

  // Addresses step by one word after each granted write
  always_ff @(posedge clk_i) begin
    if (accept) begin
      src_q <= burst.src;
      dst_q <= burst.dst;
      len_q <= burst.len;
    end else if (state_q == BE_WR_REQ && mem_gnt_i) begin
      src_q <= src_q + 1'b1;
      dst_q <= dst_q + 1'b1;
    end
  end

  // Single data buffer
  always_ff @(posedge clk_i) begin
    if (state_q == BE_RD_WAIT && mem_rvalid_i) begin
      data_q <= mem_rdata_i;
    end
  end

  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_o && !mem_gnt_i |=>
      mem_req_o && $stable(mem_addr_o) && $stable(mem_we_o));

endmodule

/* src/dma_burst_if.sv */
`timescale 1ns/1ns
`include "dma_cfg.svh"

interface dma_burst_if import dma_pkg::*; ();

  dma_addr_t src;
  dma_addr_t dst;
  dma_addr_t len;
  logic      valid;
  logic      ready;

  // Midend side
  modport mid (
    output src, dst, len, valid,
    input  ready
  );

  // Backend side
  modport be (
    input  src, dst, len, valid,
    output ready
  );

endinterface

/* src/dma_cfg.svh */
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// Word address width, all addresses count 32-bit words
`define DMA_ADDR_W 16
`define DMA_DATA_W 32

`define DMA_JOB_FIFO_DEPTH 4

// Register index map
`define DMA_REG_ADDR_W 3
`define DMA_REG_SRC        3'd0
`define DMA_REG_DST        3'd1
`define DMA_REG_LEN        3'd2
`define DMA_REG_SRC_STRIDE 3'd3
`define DMA_REG_DST_STRIDE 3'd4
`define DMA_REG_REPS       3'd5
`define DMA_REG_LAUNCH     3'd6
`define DMA_REG_DONE       3'd7

`endif

/* src/dma_core_wrap.sv */
`timescale 1ns/1ns
`include "dma_cfg.svh"

module dma_core_wrap import dma_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // Register bus
  input  logic                       reg_valid_i,
  input  logic                       reg_write_i,
  input  logic [`DMA_REG_ADDR_W-1:0] reg_addr_i,
  input  dma_data_t                  reg_wdata_i,
  output logic                       reg_ready_o,
  output dma_data_t                  reg_rdata_o,
  // Memory port
  output logic                       mem_req_o,
  output logic                       mem_we_o,
  output dma_addr_t                  mem_addr_o,
  output dma_data_t                  mem_wdata_o,
  input  logic                       mem_gnt_i,
  input  logic                       mem_rvalid_i,
  input  dma_data_t                  mem_rdata_i
);

  dma_nd_job_t fe_job, fifo_job;
  logic        fe_valid, fe_ready;
  logic        fifo_valid, fifo_ready;
  logic        burst_done, job_done;
  logic        mid_busy, be_busy;

  dma_burst_if burst ();

  dma_reg_frontend i_dma_frontend (
    .clk_i,
    .rst_n_i,
    .reg_valid_i,
    .reg_write_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_ready_o,
    .reg_rdata_o,
    .job_o          ( fe_job              ),
    .job_valid_o    ( fe_valid            ),
    .job_ready_i    ( fe_ready            ),
    .job_done_i     ( job_done            ),
    .backend_busy_i ( mid_busy || be_busy )
  );

  dma_job_fifo #(
    .DEPTH ( `DMA_JOB_FIFO_DEPTH )
  ) i_job_fifo (
    .clk_i,
    .rst_n_i,
    .data_i  ( fe_job     ),
    .valid_i ( fe_valid   ),
    .ready_o ( fe_ready   ),
    .data_o  ( fifo_job   ),
    .valid_o ( fifo_valid ),
    .ready_i ( fifo_ready )
  );

  dma_nd_midend i_nd_midend (
    .clk_i,
    .rst_n_i,
    .job_i        ( fifo_job   ),
    .job_valid_i  ( fifo_valid ),
    .job_ready_o  ( fifo_ready ),
    .burst        ( burst      ),
    .burst_done_i ( burst_done ),
    .job_done_o   ( job_done   ),
    .busy_o       ( mid_busy   )
  );

  dma_backend i_backend (
    .clk_i,
    .rst_n_i,
    .burst        ( burst      ),
    .burst_done_o ( burst_done ),
    .mem_req_o,
    .mem_we_o,
    .mem_addr_o,
    .mem_wdata_o,
    .mem_gnt_i,
    .mem_rvalid_i,
    .mem_rdata_i,
    .busy_o       ( be_busy    )
  );

endmodule

/* src/dma_job_fifo.sv */
`timescale 1ns/1ns
`include "dma_cfg.svh"

module dma_job_fifo import dma_pkg::*; #(
  parameter int unsigned DEPTH = `DMA_JOB_FIFO_DEPTH
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  dma_nd_job_t data_i,
  input  logic        valid_i,
  output logic        ready_o,
  output dma_nd_job_t data_o,
  output logic        valid_o,
  input  logic        ready_i
);

  localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  dma_nd_job_t         mem_q [DEPTH];
  logic [PtrW-1:0]     wr_ptr_q, rd_ptr_q;
  logic [PtrW-1:0]     wr_ptr_nxt, rd_ptr_nxt;
  logic                full_q, empty_q;
  logic                push, pop;

  assign ready_o = !full_q;
  assign valid_o = !empty_q;
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i && !full_q;
  assign pop  = ready_i && !empty_q;

  assign wr_ptr_nxt = wr_ptr_q + 1'b1;
  assign rd_ptr_nxt = rd_ptr_q + 1'b1;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      full_q   <= 1'b0;
      empty_q  <= 1'b1;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_nxt;
      if (pop)  rd_ptr_q <= rd_ptr_nxt;
      // Flags only move when exactly one side is active
      if (push && !pop) begin
        empty_q <= 1'b0;
        full_q  <= (wr_ptr_nxt == rd_ptr_q);
      end else if (pop && !push) begin
        full_q  <= 1'b0;
        empty_q <= (rd_ptr_nxt == wr_ptr_q);
      end
    end
  end

  // A full FIFO has equal pointers and is never empty
  a_full_ptrs: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    full_q |-> (wr_ptr_q == rd_ptr_q) && !empty_q);

endmodule

/* src/dma_nd_midend.sv */
`timescale 1ns/1ns
`include "dma_cfg.svh"

module dma_nd_midend import dma_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  dma_nd_job_t job_i,
  input  logic        job_valid_i,
  output logic        job_ready_o,
  dma_burst_if.mid    burst,
  input  logic        burst_done_i,
  output logic        job_done_o,
  output logic        busy_o
);

  typedef enum logic [1:0] {
    MID_IDLE,
    MID_ISSUE,
    MID_WAIT
  } mid_state_e;

  mid_state_e state_q;
  dma_addr_t  src_q, dst_q, len_q;
  dma_addr_t  src_stride_q, dst_stride_q, reps_q;
  dma_addr_t  row_q, row_nxt;
  logic       job_done_q;
  logic       accept;

  assign job_ready_o = (state_q == MID_IDLE);
  assign accept      = job_valid_i && job_ready_o;
  assign row_nxt     = row_q + 1'b1;

  assign burst.src   = src_q;
  assign burst.dst   = dst_q;
  assign burst.len   = len_q;
  assign burst.valid = (state_q == MID_ISSUE);

  assign job_done_o = job_done_q;
  assign busy_o     = (state_q != MID_IDLE);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= MID_IDLE;
      row_q      <= '0;
      job_done_q <= 1'b0;
    end else begin
      job_done_q <= 1'b0;
      case (state_q)
        MID_IDLE: begin
          if (accept) begin
            row_q <= '0;
            // Zero reps finishes right away
            if (job_i.reps == '0) begin
              job_done_q <= 1'b1;
            end else begin
              state_q <= MID_ISSUE;
            end
          end
        end
        MID_ISSUE: begin
          if (burst.ready) state_q <= MID_WAIT;
        end
        MID_WAIT: begin
          if (burst_done_i) begin
            row_q <= row_nxt;
            if (row_nxt == reps_q) begin
              state_q    <= MID_IDLE;
              job_done_q <= 1'b1;
            end else begin
              state_q <= MID_ISSUE;
            end
          end
        end
        default: state_q <= MID_IDLE;
      endcase
    end
  end

  // Job payload and row addresses
  always_ff @(posedge clk_i) begin
    if (accept) begin
      src_q        <= job_i.src;
      dst_q        <= job_i.dst;
      len_q        <= job_i.len;
      src_stride_q <= job_i.src_stride;
      dst_stride_q <= job_i.dst_stride;
      reps_q       <= job_i.reps;
    end else if (state_q == MID_WAIT && burst_done_i) begin
      src_q <= src_q + src_stride_q;
      dst_q <= dst_q + dst_stride_q;
    end
  end

  a_burst_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    burst.valid && !burst.ready |=>
      burst.valid && $stable(burst.src) && $stable(burst.dst) && $stable(burst.len));

endmodule

/* src/dma_pkg.sv */
`include "dma_cfg.svh"

package dma_pkg;

  typedef logic [`DMA_ADDR_W-1:0] dma_addr_t;
  typedef logic [`DMA_DATA_W-1:0] dma_data_t;

  typedef enum logic [`DMA_REG_ADDR_W-1:0] {
    REG_SRC        = `DMA_REG_SRC,
    REG_DST        = `DMA_REG_DST,
    REG_LEN        = `DMA_REG_LEN,
    REG_SRC_STRIDE = `DMA_REG_SRC_STRIDE,
    REG_DST_STRIDE = `DMA_REG_DST_STRIDE,
    REG_REPS       = `DMA_REG_REPS,
    REG_LAUNCH     = `DMA_REG_LAUNCH,
    REG_DONE       = `DMA_REG_DONE
  } dma_reg_e;

  // One 2D job, len in words, reps is the number of rows
  typedef struct packed {
    dma_addr_t src;
    dma_addr_t dst;
    dma_addr_t len;
    dma_addr_t src_stride;
    dma_addr_t dst_stride;
    dma_addr_t reps;
  } dma_nd_job_t;

endpackage

/* src/dma_reg_frontend.sv */
`timescale 1ns/1ns
`include "dma_cfg.svh"

module dma_reg_frontend import dma_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       reg_valid_i,
  input  logic                       reg_write_i,
  input  logic [`DMA_REG_ADDR_W-1:0] reg_addr_i,
  input  dma_data_t                  reg_wdata_i,
  output logic                       reg_ready_o,
  output dma_data_t                  reg_rdata_o,
  output dma_nd_job_t                job_o,
  output logic                       job_valid_o,
  input  logic                       job_ready_i,
  input  logic                       job_done_i,
  input  logic                       backend_busy_i
);

  localparam int unsigned PadW = `DMA_DATA_W - `DMA_ADDR_W;

  dma_addr_t src_q, dst_q, len_q;
  dma_addr_t src_stride_q, dst_stride_q, reps_q;
  dma_addr_t next_id_q, done_cnt_q, outstanding;
  logic      is_write, is_launch, busy;

  assign is_write  = reg_valid_i && reg_write_i;
  assign is_launch = reg_valid_i && !reg_write_i && (reg_addr_i == REG_LAUNCH);

  // Launch stalls on a full FIFO, everything else completes at once
  assign reg_ready_o = reg_valid_i && (!is_launch || job_ready_i);

  assign job_valid_o = is_launch;
  assign job_o       = '{src:        src_q,
                         dst:        dst_q,
                         len:        len_q,
                         src_stride: src_stride_q,
                         dst_stride: dst_stride_q,
                         reps:       reps_q};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      src_q        <= '0;
      dst_q        <= '0;
      len_q        <= '0;
      src_stride_q <= '0;
      dst_stride_q <= '0;
      reps_q       <= '0;
    end else if (is_write) begin
      case (dma_reg_e'(reg_addr_i))
        REG_SRC:        src_q        <= reg_wdata_i[`DMA_ADDR_W-1:0];
        REG_DST:        dst_q        <= reg_wdata_i[`DMA_ADDR_W-1:0];
        REG_LEN:        len_q        <= reg_wdata_i[`DMA_ADDR_W-1:0];
        REG_SRC_STRIDE: src_stride_q <= reg_wdata_i[`DMA_ADDR_W-1:0];
        REG_DST_STRIDE: dst_stride_q <= reg_wdata_i[`DMA_ADDR_W-1:0];
        REG_REPS:       reps_q       <= reg_wdata_i[`DMA_ADDR_W-1:0];
        default: ;
      endcase
    end
  end

  // Job ids and completions
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      next_id_q  <= '0;
      done_cnt_q <= '0;
    end else begin
      if (is_launch && job_ready_i) begin
        next_id_q <= next_id_q + 1'b1;
      end
      if (job_done_i) begin
        done_cnt_q <= done_cnt_q + 1'b1;
      end
    end
  end

  assign outstanding = next_id_q - done_cnt_q;
  assign busy        = backend_busy_i || (outstanding != '0);

  always_comb begin
    case (dma_reg_e'(reg_addr_i))
      REG_SRC:        reg_rdata_o = {{PadW{1'b0}}, src_q};
      REG_DST:        reg_rdata_o = {{PadW{1'b0}}, dst_q};
      REG_LEN:        reg_rdata_o = {{PadW{1'b0}}, len_q};
      REG_SRC_STRIDE: reg_rdata_o = {{PadW{1'b0}}, src_stride_q};
      REG_DST_STRIDE: reg_rdata_o = {{PadW{1'b0}}, dst_stride_q};
      REG_REPS:       reg_rdata_o = {{PadW{1'b0}}, reps_q};
      REG_LAUNCH:     reg_rdata_o = {{PadW{1'b0}}, next_id_q};
      default:        reg_rdata_o = {busy, {(PadW-1){1'b0}}, done_cnt_q};
    endcase
  end

  // A stalled launch stays on the bus with the same job until the FIFO takes it
  a_launch_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    job_valid_o && !job_ready_i |=> job_valid_o && $stable(job_o));

endmodule
